//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_tenyr_soc
FILELIST  := tenyr_soc.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/soc_checker.sv
`default_nettype none

module soc_checker (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             halt,
    input  wire [tenyr_pkg::addr_width-1:0] paddr,
    input  wire                             psel,
    input  wire                             penable,
    input  wire                             pwrite,
    input  wire [tenyr_pkg::data_width-1:0] prdata,
    input  wire                             pready,
    input  wire                             pslverr,
    input  wire [7:0]                       led,
    input  wire [6:0]                       seg,
    input  wire [3:0]                       an,
    input  wire [tenyr_pkg::data_width-1:0] exp_rdata,
    input  wire                             exp_err,
    input  wire [15:0]                      exp_disp,
    input  wire [6:0]                       exp_led,
    output int                              errors,
    output int                              an_steps
);

    int         err_count  = 0;
    int         step_count = 0;
    int         acc_cycles = 0;
    logic [3:0] last_an    = 4'b1110;

    assign errors   = err_count;
    assign an_steps = step_count;

    // Lit segments of a hex digit, active high, bit 6 is g and bit 0 is a
    function automatic logic [6:0] lit_segments(input logic [3:0] digit);
        case (digit)
            4'h0: return 7'b0111111;
            4'h1: return 7'b0000110;
            4'h2: return 7'b1011011;
            4'h3: return 7'b1001111;
            4'h4: return 7'b1100110;
            4'h5: return 7'b1101101;
            4'h6: return 7'b1111101;
            4'h7: return 7'b0000111;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1101111;
            4'ha: return 7'b1110111;
            4'hb: return 7'b1111100;
            4'hc: return 7'b0111001;
            4'hd: return 7'b1011110;
            4'he: return 7'b1111001;
            default: return 7'b1110001;
        endcase
    endfunction

    function automatic logic [6:0] expected_seg(input logic [15:0] value, input logic [3:0] an_val);
        logic [3:0] nibble;
        case (an_val)
            4'b1110: nibble = value[3:0];
            4'b1101: nibble = value[7:4];
            4'b1011: nibble = value[11:8];
            default: nibble = value[15:12];
        endcase
        return ~lit_segments(nibble);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %0s at addr %h: expected %h, got %h", name, paddr, expected, actual);
            err_count++;
        end
    endtask

    // Outputs are sampled on the falling edge, half a cycle after they settle
    always @(negedge clk) begin
        if (!rst_n) begin
            acc_cycles = 0;
            last_an    = 4'b1110;
            check_value("pready", 32'(1'b0), 32'(pready));
            check_value("pslverr", 32'(1'b0), 32'(pslverr));
            check_value("led", 32'({halt, 7'b0}), 32'(led));
            check_value("an", 32'(4'b1110), 32'(an));
        end else begin
            // Halt sends the access count back to the start
            if (psel && penable && !halt) begin
                acc_cycles = acc_cycles + 1;
            end else begin
                acc_cycles = 0;
            end
            check_value("pready", 32'(acc_cycles == 2), 32'(pready));
            if (pready && psel && penable) begin
                check_value("pslverr", 32'(exp_err), 32'(pslverr));
                if (!pwrite) begin
                    check_value("prdata", exp_rdata, prdata);
                end
            end else begin
                check_value("pslverr", 32'(1'b0), 32'(pslverr));
            end
            check_value("led", 32'({halt, exp_led}), 32'(led));
            if (an != last_an) begin
                check_value("an", 32'({last_an[2:0], last_an[3]}), 32'(an));
                check_value("seg", 32'(expected_seg(exp_disp, an)), 32'(seg));
                step_count++;
                last_an = an;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_tenyr_soc.sv
`default_nettype none

module tb_tenyr_soc;

    import tenyr_pkg::*;

    localparam int ram_words      = 1024;
    localparam int scan_div       = 16;
    localparam int timeout_cycles = 100;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  halt;
    logic [addr_width-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [data_width-1:0] pwdata;
    wire  [data_width-1:0] prdata;
    wire                   pready;
    wire                   pslverr;
    wire  [7:0]            led;
    wire  [6:0]            seg;
    wire  [3:0]            an;

    // Reference model state
    logic [data_width-1:0] mem_model [logic [addr_width-1:0]];
    logic [15:0]           disp_model;
    logic [6:0]            led_model;
    logic [addr_width-1:0] addr_list [$];

    // Expectation for the transfer in flight
    logic [data_width-1:0] exp_rdata;
    logic                  exp_err;

    int chk_errors;
    int an_steps;
    int tb_errors;
    int tests_run;
    int tests_failed;
    int errors_at_start;

    always #50 clk = ~clk;

    tenyr_soc #(
        .ram_words (ram_words),
        .scan_div  (scan_div)
    ) dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .halt    (halt),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .led     (led),
        .seg     (seg),
        .an      (an)
    );

    soc_checker chk0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .halt      (halt),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .led       (led),
        .seg       (seg),
        .an        (an),
        .exp_rdata (exp_rdata),
        .exp_err   (exp_err),
        .exp_disp  (disp_model),
        .exp_led   (led_model),
        .errors    (chk_errors),
        .an_steps  (an_steps)
    );

    // Expected {pslverr, prdata} for a read at addr, from the address map
    function automatic logic [data_width:0] expected_read(input logic [addr_width-1:0] addr);
        if (addr < ram_words) begin
            if (mem_model.exists(addr)) begin
                return {1'b0, mem_model[addr]};
            end
            return '0;
        end else if (addr == seg7_addr) begin
            return {1'b0, {(data_width-16){1'b0}}, disp_model};
        end else if (addr == led_addr) begin
            return {1'b0, {(data_width-8){1'b0}}, halt, led_model};
        end
        return {1'b1, {data_width{1'b0}}};
    endfunction

    function automatic void model_write(input logic [addr_width-1:0] addr,
                                        input logic [data_width-1:0] data);
        if (addr < ram_words) begin
            mem_model[addr] = data;
        end else if (addr == seg7_addr) begin
            disp_model = data[15:0];
        end else if (addr == led_addr) begin
            led_model = data[6:0];
        end
    endfunction

    // Any address above the LED register hits nothing
    function automatic logic [addr_width-1:0] random_unmapped();
        logic [addr_width-1:0] a;
        a = $urandom;
        if (a <= led_addr) begin
            a = a + led_addr + 1;
        end
        return a;
    endfunction

    // Called and returns 10 units after a rising edge
    task automatic bus_transfer(input logic write, input logic [addr_width-1:0] addr,
                                input logic [data_width-1:0] data);
        logic [data_width:0] expect_word;
        int                  waited;
        logic                done;
        expect_word = expected_read(addr);
        exp_rdata   = expect_word[data_width-1:0];
        exp_err     = expect_word[data_width];
        paddr   = addr;
        pwrite  = write;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #10;
        penable = 1'b1;
        waited  = 0;
        done    = 1'b0;
        while (!done && waited < timeout_cycles) begin
            @(negedge clk);
            if (pready) begin
                done = 1'b1;
            end
            waited++;
        end
        @(posedge clk);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
        if (!done) begin
            $display("Timeout: no pready within %0d cycles for address %h", timeout_cycles, addr);
            tb_errors++;
        end else if (write) begin
            model_write(addr, data);
        end
    endtask

    // Halt rises together with penable and stays high for the given cycles
    task automatic halted_transfer(input logic write, input logic [addr_width-1:0] addr,
                                   input logic [data_width-1:0] data, input int cycles);
        fork
            bus_transfer(write, addr, data);
            begin
                @(posedge clk);
                #10;
                halt = 1'b1;
                repeat (cycles) @(posedge clk);
                #10;
                halt = 1'b0;
            end
        join
    endtask

    task automatic wait_scan();
        int start;
        int waited;
        start  = an_steps;
        waited = 0;
        while ((an_steps - start) < 4 && waited < 4 * scan_div + 4) begin
            @(posedge clk);
            waited++;
        end
        #10;
        if ((an_steps - start) < 4) begin
            $display("Display scan did not step through all four digits in %0d cycles", waited);
            tb_errors++;
        end
    endtask

    task automatic begin_test();
        errors_at_start = chk_errors + tb_errors;
    endtask

    task automatic end_test(input string name);
        int found;
        found = chk_errors + tb_errors - errors_at_start;
        tests_run++;
        if (found != 0) begin
            tests_failed++;
            $display("Test %0s: FAIL with %0d errors", name, found);
        end else begin
            $display("Test %0s: ok", name);
        end
    endtask

    initial begin
        int                    n;
        logic [addr_width-1:0] a;
        logic [data_width-1:0] d;
        void'($urandom(41));
        rst_n      = 1'b0;
        halt       = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        disp_model = '0;
        led_model  = '0;
        exp_rdata  = '0;
        exp_err    = 1'b0;
        tb_errors  = 0;
        tests_run  = 0;
        tests_failed = 0;

        // Reset state, checked by chk0 while rst_n is low
        begin_test();
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(posedge clk);
        #10;
        bus_transfer(1'b0, seg7_addr, '0);
        bus_transfer(1'b0, led_addr, '0);
        end_test("reset state");

        begin_test();
        for (int i = 0; i < 200; i++) begin
            a = $urandom % ram_words;
            d = $urandom;
            addr_list.push_back(a);
            bus_transfer(1'b1, a, d);
        end
        foreach (addr_list[k]) begin
            bus_transfer(1'b0, addr_list[k], '0);
        end
        end_test("ram readback");

        // One transfer to each target, pready timing checked by chk0
        begin_test();
        bus_transfer(1'b1, addr_list[0], $urandom);
        bus_transfer(1'b0, addr_list[0], '0);
        bus_transfer(1'b0, seg7_addr, '0);
        bus_transfer(1'b0, led_addr, '0);
        bus_transfer(1'b0, random_unmapped(), '0);
        end_test("transfer timing");

        begin_test();
        for (int i = 0; i < 20; i++) begin
            bus_transfer(1'b1, random_unmapped(), $urandom);
            bus_transfer(1'b0, random_unmapped(), '0);
        end
        foreach (addr_list[k]) begin
            bus_transfer(1'b0, addr_list[k], '0);
        end
        end_test("unmapped addresses");

        begin_test();
        for (int i = 0; i < 3; i++) begin
            bus_transfer(1'b1, seg7_addr, $urandom);
            bus_transfer(1'b0, seg7_addr, '0);
            wait_scan();
        end
        end_test("display");

        begin_test();
        for (int i = 0; i < 4; i++) begin
            a = addr_list[i];
            n = 3 + $urandom % 18;
            halted_transfer(1'b1, a, $urandom, n);
            n = 3 + $urandom % 18;
            halted_transfer(1'b0, a, '0, n);
        end
        n = 3 + $urandom % 18;
        halted_transfer(1'b1, led_addr, $urandom, n);
        bus_transfer(1'b0, led_addr, '0);
        bus_transfer(1'b1, led_addr, $urandom);
        bus_transfer(1'b0, led_addr, '0);
        end_test("halt");

        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_failed, chk_errors + tb_errors);
        if (tests_failed == 0 && chk_errors + tb_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/data_ram.sv
`default_nettype none

module data_ram #(
    parameter int ram_words = 1024
) (
    input  wire                              clk,
    input  wire                              en,
    input  wire                              we,
    input  wire [tenyr_pkg::addr_width-1:0]  addr,
    input  wire [tenyr_pkg::data_width-1:0]  wdata,
    output logic [tenyr_pkg::data_width-1:0] rdata
);

    import tenyr_pkg::*;

    localparam int addr_bits = $clog2(ram_words);

    logic [data_width-1:0] mem [ram_words];
    logic [addr_bits-1:0]  index;

    // Only the low bits reach the array
    assign index = addr[addr_bits-1:0];

    // Read-first port, output registered one clock after en
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[index] <= wdata;
            end
            rdata <= mem[index];
        end
    end

    // The fabric decode must keep accesses inside the array
    a_addr_in_range: assert property (@(posedge clk)
        en |-> (addr < ram_words));

endmodule

`default_nettype wire

//--- hdl/io_fabric.sv
`default_nettype none

module io_fabric #(
    parameter int ram_words = 1024
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             halt,
    input  wire [tenyr_pkg::addr_width-1:0] paddr,
    input  wire                             psel,
    input  wire                             penable,
    input  wire                             pwrite,
    input  wire [tenyr_pkg::data_width-1:0] pwdata,
    output logic [tenyr_pkg::data_width-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr,
    output logic                            ram_en,
    output logic                            ram_we,
    output logic [tenyr_pkg::addr_width-1:0] ram_addr,
    output logic [tenyr_pkg::data_width-1:0] ram_wdata,
    input  wire [tenyr_pkg::data_width-1:0] ram_rdata,
    output logic                            disp_we,
    output logic [15:0]                     disp_wdata,
    input  wire [15:0]                      disp_value,
    output logic [7:0]                      led
);

    import tenyr_pkg::*;

    typedef enum logic [1:0] {tgt_ram, tgt_disp, tgt_led, tgt_none} target_t;
    typedef enum logic {acc_first, acc_second} acc_state_t;

    target_t    target;
    acc_state_t state;
    logic       access;
    logic [6:0] led_bits;

    assign access = psel && penable;

    // Address decode
    always_comb begin
        if (paddr < ram_words) begin
            target = tgt_ram;
        end else if (paddr == seg7_addr) begin
            target = tgt_disp;
        end else if (paddr == led_addr) begin
            target = tgt_led;
        end else begin
            target = tgt_none;
        end
    end

    // Halt drops back to the first access cycle, so the access restarts afterwards
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= acc_first;
        end else if (halt || !access) begin
            state <= acc_first;
        end else if (state == acc_first) begin
            state <= acc_second;
        end else begin
            state <= acc_first;
        end
    end

    assign pready  = access && !halt && (state == acc_second);
    assign pslverr = pready && (target == tgt_none);

    // RAM access is issued in the first access cycle
    assign ram_en    = access && !halt && (state == acc_first) && (target == tgt_ram);
    assign ram_we    = ram_en && pwrite;
    assign ram_addr  = paddr;
    assign ram_wdata = pwdata;

    assign disp_we    = pready && pwrite && (target == tgt_disp);
    assign disp_wdata = pwdata[15:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led_bits <= '0;
        end else if (pready && pwrite && (target == tgt_led)) begin
            led_bits <= pwdata[6:0];
        end
    end

    // Top LED mirrors the halt input
    assign led = {halt, led_bits};

    // Read data mux, zero unless a read completes
    always_comb begin
        prdata = '0;
        if (pready && !pwrite) begin
            case (target)
                tgt_ram:  prdata = ram_rdata;
                tgt_disp: prdata = {{(data_width-16){1'b0}}, disp_value};
                tgt_led:  prdata = {{(data_width-8){1'b0}}, led};
                default:  prdata = '0;
            endcase
        end
    end

    // A waiting access is held by the requester until it completes
    a_access_held: assert property (@(posedge clk) disable iff (!rst_n)
        (access && !pready) |=> (access && $stable(paddr) && $stable(pwrite)
                                 && $stable(pwdata)));

    // The access phase is entered only from the setup phase
    a_setup_first: assert property (@(posedge clk) disable iff (!rst_n)
        (access && !$past(access)) |-> $past(psel && !penable));

endmodule

`default_nettype wire

//--- hdl/seg7_display.sv
`default_nettype none

module seg7_display #(
    parameter int scan_div = 16
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         we,
    input  wire [15:0]  wdata,
    output logic [15:0] value,
    output logic [6:0]  seg,
    output logic [3:0]  an
);

    import tenyr_pkg::*;

    localparam int cnt_bits = (scan_div > 1) ? $clog2(scan_div) : 1;
    localparam logic [cnt_bits-1:0] cnt_last = cnt_bits'(scan_div - 1);

    logic [cnt_bits-1:0] scan_cnt;
    logic [1:0]          digit;
    logic [3:0]          nibble;

    // Displayed value register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value <= '0;
        end else if (we) begin
            value <= wdata;
        end
    end

    // Scan divider, one digit every scan_div clocks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_cnt <= '0;
        end else if (scan_cnt == cnt_last) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // Digit index, 0 is the least significant nibble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digit <= 2'd0;
        end else if (scan_cnt == cnt_last) begin
            digit <= digit + 2'd1;
        end
    end

    // Anodes are active low
    always_comb begin
        case (digit)
            2'd0:    an = 4'b1110;
            2'd1:    an = 4'b1101;
            2'd2:    an = 4'b1011;
            default: an = 4'b0111;
        endcase
    end

    assign nibble = value[digit*4 +: 4];
    assign seg    = seg7_encode(nibble);

endmodule

`default_nettype wire

//--- hdl/tenyr_pkg.sv
`default_nettype none

package tenyr_pkg;

    // Bus widths, word addressed
    parameter int addr_width = 32;
    parameter int data_width = 32;

    // Device registers sit just above the largest RAM
    parameter logic [addr_width-1:0] seg7_addr = 32'h0000_0400;
    parameter logic [addr_width-1:0] led_addr  = 32'h0000_0401;

    // Hex digit to active-low segments, bit 6 is g and bit 0 is a
    function automatic logic [6:0] seg7_encode(input logic [3:0] digit);
        logic [6:0] segs;
        case (digit)
            4'h0: segs = 7'h40;
            4'h1: segs = 7'h79;
            4'h2: segs = 7'h24;
            4'h3: segs = 7'h30;
            4'h4: segs = 7'h19;
            4'h5: segs = 7'h12;
            4'h6: segs = 7'h02;
            4'h7: segs = 7'h78;
            4'h8: segs = 7'h00;
            4'h9: segs = 7'h10;
            4'ha: segs = 7'h08;
            4'hb: segs = 7'h03;
            4'hc: segs = 7'h46;
            4'hd: segs = 7'h21;
            4'he: segs = 7'h06;
            default: segs = 7'h0e;
        endcase
        return segs;
    endfunction

endpackage

`default_nettype wire

//--- hdl/tenyr_soc.sv
`default_nettype none

module tenyr_soc #(
    parameter int ram_words = 1024,
    parameter int scan_div  = 16
) (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              halt,
    input  wire [tenyr_pkg::addr_width-1:0]  paddr,
    input  wire                              psel,
    input  wire                              penable,
    input  wire                              pwrite,
    input  wire [tenyr_pkg::data_width-1:0]  pwdata,
    output logic [tenyr_pkg::data_width-1:0] prdata,
    output logic                             pready,
    output logic                             pslverr,
    output logic [7:0]                       led,
    output logic [6:0]                       seg,
    output logic [3:0]                       an
);

    import tenyr_pkg::*;

    // Fabric to RAM
    logic                  ram_en;
    logic                  ram_we;
    logic [addr_width-1:0] ram_addr;
    logic [data_width-1:0] ram_wdata;
    logic [data_width-1:0] ram_rdata;

    // Fabric to display
    logic        disp_we;
    logic [15:0] disp_wdata;
    logic [15:0] disp_value;

    io_fabric #(
        .ram_words (ram_words)
    ) fabric (
        .clk        (clk),
        .rst_n      (rst_n),
        .halt       (halt),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata),
        .disp_we    (disp_we),
        .disp_wdata (disp_wdata),
        .disp_value (disp_value),
        .led        (led)
    );

    data_ram #(
        .ram_words (ram_words)
    ) ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    seg7_display #(
        .scan_div (scan_div)
    ) seg7 (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (disp_we),
        .wdata (disp_wdata),
        .value (disp_value),
        .seg   (seg),
        .an    (an)
    );

endmodule

`default_nettype wire

//--- tenyr_soc.f
hdl/tenyr_pkg.sv
hdl/io_fabric.sv
hdl/data_ram.sv
hdl/seg7_display.sv
hdl/tenyr_soc.sv
bench/soc_checker.sv
bench/tb_tenyr_soc.sv
